// File: Bender.yml
package:
  name: pcalc_unit

dependencies: {}

sources:
  # Hit-point stage RTL, in compile order.
  - files:
      - hw/rt_pkg.sv
      - hw/pcalc_math.sv
      - hw/pipe_valid_stall.sv
      - hw/fifo.sv
      - hw/pcalc_unit.sv

  # Testbench, top module tb_pcalc_unit.
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_pcalc_unit.sv

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0; // Released just after the third edge.
  end

endmodule

// File: dv/tb_pcalc_unit.sv
`timescale 1ns/1ps

module tb_pcalc_unit
  import rt_pkg::*;
;

  localparam int FIFO_DEPTH     = 6;
  localparam int N_SINGLE       = 4;
  localparam int N_STREAM       = 16;
  localparam int N_RANDOM       = 300;
  localparam int N_RAYS         = N_SINGLE + N_STREAM + FIFO_DEPTH + 1 + N_RANDOM;
  localparam int TIMEOUT_CYCLES = N_RAYS * 20 + 200;
  localparam int DRAIN_LIMIT    = 100;

  logic             clk;
  logic             reset;
  logic             rs_to_pcalc_valid;
  rs_to_pcalc_t     rs_to_pcalc_data;
  logic             rs_to_pcalc_stall;
  logic             pcalc_to_shader_valid;
  pcalc_to_shader_t pcalc_to_shader_data;
  logic             pcalc_to_shader_stall;

  pcalc_to_shader_t expected_q[$];
  int               out_cycle_q[$];
  int               error_count   = 0;
  int               compare_count = 0;
  int               accept_count  = 0;
  int               out_count     = 0;
  int               cycle         = 0;
  logic [31:0]      lfsr_state    = 32'd96918;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clk (.clk, .reset);

  pcalc_unit #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
    .clk,
    .reset,
    .rs_to_pcalc_valid,
    .rs_to_pcalc_data,
    .rs_to_pcalc_stall,
    .pcalc_to_shader_valid,
    .pcalc_to_shader_data,
    .pcalc_to_shader_stall
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return val;
  endfunction

  // origin + floor(t * dir / 2^16), wrapping to 32 bits.
  function automatic fixed_t axis_ref(input fixed_t o, input fixed_t d, input fixed_t t);
    logic signed [63:0] t_wide;
    logic signed [63:0] d_wide;
    logic signed [63:0] prod;
    t_wide = t;
    d_wide = d;
    prod   = (t_wide * d_wide) >>> FRAC_BITS;
    return o + prod[31:0];
  endfunction

  function automatic pcalc_to_shader_t expected_result(input rs_to_pcalc_t r);
    pcalc_to_shader_t e;
    e.ray_id  = r.ray_id;
    e.tri_id  = r.tri_id;
    e.p_int.x = axis_ref(r.ray_vec.origin.x, r.ray_vec.dir.x, r.t_int);
    e.p_int.y = axis_ref(r.ray_vec.origin.y, r.ray_vec.dir.y, r.t_int);
    e.p_int.z = axis_ref(r.ray_vec.origin.z, r.ray_vec.dir.z, r.t_int);
    return e;
  endfunction

  function automatic rs_to_pcalc_t random_ray();
    rs_to_pcalc_t r;
    r.ray_id             = ray_id_t'(rand_bits(8));
    r.tri_id             = tri_id_t'(rand_bits(12));
    r.ray_vec.origin.x   = fixed_t'(rand_bits(32));
    r.ray_vec.origin.y   = fixed_t'(rand_bits(32));
    r.ray_vec.origin.z   = fixed_t'(rand_bits(32));
    r.ray_vec.dir.x      = fixed_t'(rand_bits(32));
    r.ray_vec.dir.y      = fixed_t'(rand_bits(32));
    r.ray_vec.dir.z      = fixed_t'(rand_bits(32));
    r.t_int              = fixed_t'(rand_bits(32));
    return r;
  endfunction

  function automatic rs_to_pcalc_t make_ray(input ray_id_t rid, input tri_id_t tid,
                                            input vector_t origin, input vector_t dir,
                                            input fixed_t t);
    rs_to_pcalc_t r;
    r.ray_id         = rid;
    r.tri_id         = tid;
    r.ray_vec.origin = origin;
    r.ray_vec.dir    = dir;
    r.t_int          = t;
    return r;
  endfunction

  // Hand-picked corner cases.
  function automatic rs_to_pcalc_t corner_ray(input int idx);
    case (idx)
      0: return make_ray(8'h11, 12'h101, {32'h0001_8000, 32'hFFFD_C000, 32'h0000_0000},
                         {32'h0000_8000, 32'hFFFF_4000, 32'h0001_0000}, 32'h0002_0000);
      1: return make_ray(8'h22, 12'h202, {32'h000A_0000, 32'h0000_0000, 32'hFFFF_FFFF},
                         {32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0003}, 32'hFFFF_8000);
      2: return make_ray(8'h33, 12'hFFF, {32'h7FFF_FFFF, 32'h8000_0000, 32'h4000_0000},
                         {32'h0010_0000, 32'h7FFF_FFFF, 32'h8000_0000}, 32'h7FFF_0000);
      default: return make_ray(8'hFF, 12'h000, {32'h1234_5678, 32'h8765_4321, 32'h0000_0001},
                               {32'h7FFF_FFFF, 32'h8000_0000, 32'hDEAD_BEEF}, 32'h0000_0000);
    endcase
  endfunction

  task automatic compare_result(input pcalc_to_shader_t e, input pcalc_to_shader_t a);
    compare_count++;
    assert (a.ray_id == e.ray_id) else begin
      error_count++;
      $display("ERROR %0t: pcalc_to_shader_data.ray_id expected %h actual %h",
               $time, e.ray_id, a.ray_id);
    end
    assert (a.tri_id == e.tri_id) else begin
      error_count++;
      $display("ERROR %0t: pcalc_to_shader_data.tri_id expected %h actual %h",
               $time, e.tri_id, a.tri_id);
    end
    assert (a.p_int.x == e.p_int.x) else begin
      error_count++;
      $display("ERROR %0t: pcalc_to_shader_data.p_int.x expected %h actual %h",
               $time, e.p_int.x, a.p_int.x);
    end
    assert (a.p_int.y == e.p_int.y) else begin
      error_count++;
      $display("ERROR %0t: pcalc_to_shader_data.p_int.y expected %h actual %h",
               $time, e.p_int.y, a.p_int.y);
    end
    assert (a.p_int.z == e.p_int.z) else begin
      error_count++;
      $display("ERROR %0t: pcalc_to_shader_data.p_int.z expected %h actual %h",
               $time, e.p_int.z, a.p_int.z);
    end
  endtask

  // Scoreboard. Samples settled values at each rising edge.
  always @(posedge clk) begin
    pcalc_to_shader_t exp_out;
    if (!reset) begin
      cycle++;
      if (rs_to_pcalc_valid && !rs_to_pcalc_stall) begin
        expected_q.push_back(expected_result(rs_to_pcalc_data));
        accept_count++;
      end
      if (pcalc_to_shader_valid && !pcalc_to_shader_stall) begin
        assert (expected_q.size() != 0) else begin
          error_count++;
          $display("Output at %0t arrived with no ray outstanding", $time);
        end
        if (expected_q.size() != 0) begin
          exp_out = expected_q.pop_front();
          compare_result(exp_out, pcalc_to_shader_data);
        end
        out_cycle_q.push_back(cycle);
        out_count++;
      end
    end
  end

  // Holds the ray until the edge that takes it.
  task automatic send_ray(input rs_to_pcalc_t ray);
    logic took;
    rs_to_pcalc_valid = 1'b1;
    rs_to_pcalc_data  = ray;
    took = 1'b0;
    while (!took) begin
      @(posedge clk);
      took = !rs_to_pcalc_stall;
    end
    #1;
    rs_to_pcalc_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((expected_q.size() != 0 || pcalc_to_shader_valid) && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (waited < DRAIN_LIMIT) else begin
      error_count++;
      $display("Results still pending %0d cycles later at %0t", DRAIN_LIMIT, $time);
    end
  endtask

  initial begin
    int           edges;
    int           base;
    int           held;
    int           sent;
    logic         took;
    rs_to_pcalc_t held_ray;

    rs_to_pcalc_valid     = 1'b0;
    rs_to_pcalc_data      = '0;
    pcalc_to_shader_stall = 1'b0;
    @(negedge reset);

    repeat (3) begin
      @(posedge clk);
      #1;
      assert (!pcalc_to_shader_valid && !rs_to_pcalc_stall) else begin
        error_count++;
        $display("Valid or stall high after reset at %0t", $time);
      end
    end

    for (int i = 0; i < N_SINGLE; i++) begin
      send_ray(corner_ray(i));
      edges = 1; // Counted from the edge the ray was driven after.
      while (!pcalc_to_shader_valid && edges < 10) begin
        @(posedge clk);
        #1;
        edges++;
      end
      assert (edges == 4) else begin
        error_count++;
        $display("ERROR %0t: pcalc_to_shader_valid latency expected 4 actual %0d", $time, edges);
      end
      wait_drain();
    end

    base = out_count;
    for (int i = 0; i < N_STREAM; i++) begin
      send_ray(random_ray());
    end
    wait_drain();
    assert (out_count - base == N_STREAM &&
            out_cycle_q[base + N_STREAM - 1] - out_cycle_q[base] == N_STREAM - 1) else begin
      error_count++;
      $display("Streamed results were not delivered one per cycle");
    end

    pcalc_to_shader_stall = 1'b1;
    base = out_count;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      assert (!rs_to_pcalc_stall) else begin
        error_count++;
        $display("Input stalled after only %0d rays at %0t", i, $time);
      end
      send_ray(random_ray());
    end
    assert (rs_to_pcalc_stall) else begin
      error_count++;
      $display("Input not stalled with the FIFO committed at %0t", $time);
    end
    held     = accept_count;
    held_ray = random_ray();
    rs_to_pcalc_valid = 1'b1;
    rs_to_pcalc_data  = held_ray;
    repeat (8) begin
      @(posedge clk);
      #1;
    end
    assert (accept_count == held && rs_to_pcalc_stall) else begin
      error_count++;
      $display("A ray was taken while the FIFO was full at %0t", $time);
    end
    pcalc_to_shader_stall = 1'b0;
    send_ray(held_ray);
    wait_drain();
    assert (out_count - base == FIFO_DEPTH + 1) else begin
      error_count++;
      $display("Back-pressure delivered %0d results instead of %0d", out_count - base,
               FIFO_DEPTH + 1);
    end

    sent = 0;
    while (sent < N_RANDOM) begin
      @(posedge clk);
      took = rs_to_pcalc_valid && !rs_to_pcalc_stall;
      if (took) begin
        sent++;
      end
      #1;
      pcalc_to_shader_stall = (rand_bits(2) == 0);
      if (!rs_to_pcalc_valid || took) begin
        if (sent < N_RANDOM && rand_bits(2) != 0) begin
          rs_to_pcalc_valid = 1'b1;
          rs_to_pcalc_data  = random_ray();
        end else begin
          rs_to_pcalc_valid = 1'b0;
        end
      end
    end
    pcalc_to_shader_stall = 1'b0;
    wait_drain();
    assert (expected_q.size() == 0 && compare_count == accept_count) else begin
      error_count++;
      $display("Scoreboard holds %0d rays at the end", expected_q.size());
    end

    $display("Summary: %0d errors, %0d results compared, %0d rays accepted",
             error_count, compare_count, accept_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
    $display("Summary: %0d errors, %0d results compared, %0d rays accepted",
             error_count, compare_count, accept_count);
    $display("Errors found");
    $finish;
  end

endmodule

// File: hw/fifo.sv
`timescale 1ns/1ps

module fifo
  import rt_pkg::*;
#(
  parameter int DEPTH = 6,
  parameter int WIDTH = 116
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] data_in,
  input  logic             we,
  input  logic             re,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty,
  output credit_t          num_left_in_fifo
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_t          count;
  logic             do_wr;
  logic             do_rd;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full             = (count == credit_t'(DEPTH));
  assign empty            = (count == '0);
  assign num_left_in_fifo = credit_t'(DEPTH) - count;

  assign do_rd = re & ~empty;
  assign do_wr = we & (~full | do_rd); // Full slot frees up on a read.

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign data_out = mem[rd_ptr]; // Head entry, valid while not empty.

endmodule

// File: hw/pcalc_math.sv
`timescale 1ns/1ps

module pcalc_math
  import rt_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  ray_vec_t ray_vec,
  input  fixed_t   t,
  output vector_t  pos
);

  localparam int AXES = 3;

  // Full-width signed product of two Q16.16 values.
  typedef logic signed [2*$bits(fixed_t)-1:0] prod_t;

  // Index 2 is x, 1 is y, 0 is z, matching the vector_t layout.
  fixed_t             t_s1;
  fixed_t [AXES-1:0]  origin_s1;
  fixed_t [AXES-1:0]  dir_s1;

  fixed_t [AXES-1:0]  origin_s2;
  prod_t  [AXES-1:0]  prod_s2;

  fixed_t [AXES-1:0]  pos_q;

  // Stage 1: capture the ray.
  always_ff @(posedge clk) begin
    if (reset) begin
      t_s1      <= '0;
      origin_s1 <= '0;
      dir_s1    <= '0;
    end else begin
      t_s1      <= t;
      origin_s1 <= ray_vec.origin;
      dir_s1    <= ray_vec.dir;
    end
  end

  // Stage 2: t times dir on every axis.
  always_ff @(posedge clk) begin
    if (reset) begin
      origin_s2 <= '0;
      prod_s2   <= '0;
    end else begin
      origin_s2 <= origin_s1;
      for (int i = 0; i < AXES; i++) begin
        prod_s2[i] <= prod_t'($signed(t_s1)) * prod_t'($signed(dir_s1[i]));
      end
    end
  end

  // Stage 3: rescale and add the origin.
  always_ff @(posedge clk) begin
    if (reset) begin
      pos_q <= '0;
    end else begin
      for (int i = 0; i < AXES; i++) begin
        // Floor shift, then wrap to 32 bits.
        pos_q[i] <= origin_s2[i] + fixed_t'($signed(prod_s2[i]) >>> FRAC_BITS);
      end
    end
  end

  assign pos = pos_q; // Same bit layout as vector_t.

endmodule

// File: hw/pcalc_unit.sv
`timescale 1ns/1ps

module pcalc_unit
  import rt_pkg::*;
#(
  parameter int FIFO_DEPTH = 6
) (
  input  logic             clk,
  input  logic             reset,

  input  logic             rs_to_pcalc_valid,
  input  rs_to_pcalc_t     rs_to_pcalc_data,
  output logic             rs_to_pcalc_stall,

  output logic             pcalc_to_shader_valid,
  output pcalc_to_shader_t pcalc_to_shader_data,
  input  logic             pcalc_to_shader_stall
);

  vector_t          pos_out;

  pcalc_id_t        id_pipe_in;
  pcalc_id_t        id_pipe_out;
  logic             id_pipe_ds_valid;

  pcalc_to_shader_t pcalc_fifo_in;
  pcalc_to_shader_t pcalc_fifo_out;
  logic             pcalc_fifo_empty;
  logic             pcalc_fifo_re;
  credit_t          num_left_in_pcalc_fifo;

  // Math runs free; only the sideband marks real rays.
  pcalc_math pcalc_math_inst (
    .clk,
    .reset,
    .ray_vec (rs_to_pcalc_data.ray_vec),
    .t       (rs_to_pcalc_data.t_int),
    .pos     (pos_out)
  );

  assign id_pipe_in.ray_id = rs_to_pcalc_data.ray_id;
  assign id_pipe_in.tri_id = rs_to_pcalc_data.tri_id;

  pipe_valid_stall #(
    .WIDTH ($bits(pcalc_id_t)),
    .DEPTH (MATH_LATENCY)
  ) id_pipe_inst (
    .clk,
    .reset,
    .us_valid         (rs_to_pcalc_valid),
    .us_data          (id_pipe_in),
    .us_stall         (rs_to_pcalc_stall),
    .ds_valid         (id_pipe_ds_valid),
    .ds_data          (id_pipe_out),
    .num_left_in_fifo (num_left_in_pcalc_fifo)
  );

  // IDs line up with the position leaving the math.
  assign pcalc_fifo_in.ray_id = id_pipe_out.ray_id;
  assign pcalc_fifo_in.tri_id = id_pipe_out.tri_id;
  assign pcalc_fifo_in.p_int  = pos_out;

  fifo #(
    .DEPTH (FIFO_DEPTH),
    .WIDTH ($bits(pcalc_to_shader_t))
  ) pcalc_fifo_inst (
    .clk,
    .reset,
    .data_in          (pcalc_fifo_in),
    .we               (id_pipe_ds_valid),
    .re               (pcalc_fifo_re),
    .data_out         (pcalc_fifo_out),
    .full             (),
    .empty            (pcalc_fifo_empty),
    .num_left_in_fifo (num_left_in_pcalc_fifo)
  );

  assign pcalc_to_shader_valid = ~pcalc_fifo_empty;
  assign pcalc_to_shader_data  = pcalc_fifo_out;
  assign pcalc_fifo_re         = pcalc_to_shader_valid & ~pcalc_to_shader_stall; // Pop on transfer.

endmodule

// File: hw/pipe_valid_stall.sv
`timescale 1ns/1ps

module pipe_valid_stall
  import rt_pkg::*;
#(
  parameter int WIDTH = 20,
  parameter int DEPTH = 3
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             us_valid,
  input  logic [WIDTH-1:0] us_data,
  output logic             us_stall,
  output logic             ds_valid,
  output logic [WIDTH-1:0] ds_data,
  input  credit_t          num_left_in_fifo
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DEPTH-1:0] valid_q;
  logic [WIDTH-1:0] data_q [DEPTH];
  logic [CNT_W-1:0] in_flight;
  logic             accept;

  // Every item in flight already owns a FIFO slot.
  assign us_stall = (32'(in_flight) >= 32'(num_left_in_fifo));
  assign accept   = us_valid & ~us_stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= accept;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    data_q[0] <= us_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  // One in at the head, one out at the tail.
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + CNT_W'(accept) - CNT_W'(valid_q[DEPTH-1]);
    end
  end

  assign ds_valid = valid_q[DEPTH-1];
  assign ds_data  = data_q[DEPTH-1];

endmodule

// File: hw/rt_pkg.sv
package rt_pkg;

  // Q16.16 fixed point.
  localparam int FRAC_BITS = 16;

  // Register stages in pcalc_math.
  localparam int MATH_LATENCY = 3;

  typedef logic signed [31:0] fixed_t;

  typedef logic [7:0] ray_id_t;

  typedef logic [11:0] tri_id_t;

  // Free slots reported by the output FIFO.
  typedef logic [2:0] credit_t;

  typedef struct packed {
    fixed_t x;
    fixed_t y;
    fixed_t z;
  } vector_t;

  typedef struct packed {
    vector_t origin;
    vector_t dir;
  } ray_vec_t;

  // Scheduler to hit-point stage.
  typedef struct packed {
    ray_id_t  ray_id;
    tri_id_t  tri_id;
    ray_vec_t ray_vec;
    fixed_t   t_int;
  } rs_to_pcalc_t;

  // Hit-point stage to shader.
  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
    vector_t p_int;
  } pcalc_to_shader_t;

  // Sideband word that rides next to the math pipeline.
  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
  } pcalc_id_t;

endpackage

// File: sim.f
hw/rt_pkg.sv
hw/pcalc_math.sv
hw/pipe_valid_stall.sv
hw/fifo.sv
hw/pcalc_unit.sv
dv/tb_clock_gen.sv
dv/tb_pcalc_unit.sv
